//--- verilog/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  typedef logic [31:0] instrT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // ARM condition field, 4'b1111 is left out
  typedef enum logic [3:0] {
    condEq = 4'b0000,
    condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl
  } condT;

  // Op field in bits 27:26
  localparam logic [1:0] opDataProc = 2'b00;
  localparam logic [1:0] opMemory   = 2'b01;
  localparam logic [1:0] opBranch   = 2'b10;

  localparam logic [3:0] mulPattern = 4'b1001;  // Bits 7:4 of MUL/MLA
  localparam logic [3:0] pcReg      = 4'd15;

  // Data-processing codes that touch C and V
  localparam logic [3:0] aluSub = 4'b0010;
  localparam logic [3:0] aluRsb = 4'b0011;
  localparam logic [3:0] aluAdd = 4'b0100;
  localparam logic [3:0] aluAdc = 4'b0101;
  localparam logic [3:0] aluSbc = 4'b0110;
  localparam logic [3:0] aluRsc = 4'b0111;
  localparam logic [3:0] aluCmp = 4'b1010;
  localparam logic [3:0] aluCmn = 4'b1011;

  typedef struct packed {
    logic [1:0] flagWrite;     // {NZ, CV}
    logic       branch;
    logic       memWrite;
    logic       regWrite;
    logic       pcSrc;
    logic       memtoReg;
    logic       aluSrc;
    logic [3:0] aluControl;
    logic [2:0] multControl;
    logic       rSelect;
    logic       rsrSelect;
    logic [1:0] resultSelect;  // {multiply, shifted by register}
    logic [2:0] shiftOp;
    condT       cond;
  } exCtrlT;

  typedef struct packed {
    logic memWrite;
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
  } memCtrlT;

  // Register-number compares from the datapath
  typedef struct packed {
    logic match1EM;
    logic match2EM;
    logic match1EW;
    logic match2EW;
    logic match12DE;
  } regMatchT;

  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdW    = 2'b01,
    fwdM    = 2'b10
  } fwdSelT;

  typedef struct packed {
    logic stallF;
    logic stallD;
    logic flushD;
    logic stallE;
    logic flushE;
    logic stallM;
    logic flushM;
    logic flushW;
  } hazardT;

endpackage

`default_nettype wire

//--- verilog/pipeReg.sv
`default_nettype none

// Stage register, clear wins over enable
module pipeReg #(
  parameter type payloadT = logic [7:0]
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    en,
  input  logic    clr,
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk) begin
    if (reset || clr) begin
      q <= '0;  // Bubble
    end else if (en) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`default_nettype none

module instrDecoder (
  input  ctrlPkg::instrT  instrD,
  output logic [1:0]      regSrcD,
  output logic [1:0]      immSrcD,
  output logic            multSelectD,
  output ctrlPkg::exCtrlT decCtrl,
  output logic            pcSrcD
);

  logic       aluSrc;
  logic       memtoReg;
  logic       regWrite;
  logic       memWrite;
  logic       branch;
  logic       aluOp;
  logic [3:0] aluControl;
  logic [1:0] flagWrite;
  logic       isArith;
  logic       isDpReg;

  // Main decoder
  always_comb begin
    regSrcD     = 2'b00;
    immSrcD     = 2'b00;
    aluSrc      = 1'b0;
    memtoReg    = 1'b0;
    regWrite    = 1'b0;
    memWrite    = 1'b0;
    branch      = 1'b0;
    aluOp       = 1'b0;
    multSelectD = 1'b0;
    case (instrD[27:26])
      ctrlPkg::opDataProc: begin
        regWrite = 1'b1;
        aluOp    = 1'b1;
        if (instrD[25]) begin
          aluSrc = 1'b1;  // Rotated immediate
        end else if (instrD[7:4] == ctrlPkg::mulPattern) begin
          multSelectD = 1'b1;
        end
      end
      ctrlPkg::opMemory: begin
        immSrcD = 2'b01;  // 12-bit offset
        aluSrc  = 1'b1;
        if (instrD[20]) begin
          memtoReg = 1'b1;
          regWrite = 1'b1;
        end else begin
          regSrcD  = 2'b10;  // Store data read from Rd
          memWrite = 1'b1;
        end
      end
      ctrlPkg::opBranch: begin
        regSrcD = 2'b01;  // PC as first operand
        immSrcD = 2'b10;
        aluSrc  = 1'b1;
        branch  = 1'b1;
      end
      default: ;  // Coprocessor space decodes as a no-op
    endcase
  end

  // Only arithmetic ops produce a meaningful carry and overflow
  assign isArith = instrD[24:21] inside {ctrlPkg::aluSub, ctrlPkg::aluRsb,
                                         ctrlPkg::aluAdd, ctrlPkg::aluAdc,
                                         ctrlPkg::aluSbc, ctrlPkg::aluRsc,
                                         ctrlPkg::aluCmp, ctrlPkg::aluCmn};

  always_comb begin
    if (aluOp) begin
      aluControl = instrD[24:21];
      flagWrite  = {instrD[20], instrD[20] & isArith};
    end else begin
      aluControl = ctrlPkg::aluAdd;  // Address and branch target
      flagWrite  = 2'b00;
    end
  end

  assign isDpReg = (instrD[27:25] == 3'b000);
  assign pcSrcD  = ((instrD[15:12] == ctrlPkg::pcReg) & regWrite) | branch;

  always_comb begin
    decCtrl.flagWrite    = flagWrite;
    decCtrl.branch       = branch;
    decCtrl.memWrite     = memWrite;
    decCtrl.regWrite     = regWrite;
    decCtrl.pcSrc        = pcSrcD;
    decCtrl.memtoReg     = memtoReg;
    decCtrl.aluSrc       = aluSrc;
    decCtrl.aluControl   = aluControl;
    decCtrl.multControl  = instrD[23:21];
    decCtrl.rSelect      = isDpReg & ~instrD[4];  // Shift by immediate
    decCtrl.rsrSelect    = isDpReg & instrD[4];   // Shift by Rs
    decCtrl.resultSelect = {multSelectD, isDpReg & instrD[4]};
    decCtrl.shiftOp      = instrD[6:4];
    decCtrl.cond         = ctrlPkg::condT'(instrD[31:28]);
  end

endmodule

`default_nettype wire

//--- verilog/condCheck.sv
`default_nettype none

module condCheck (
  input  ctrlPkg::condT  cond,
  input  ctrlPkg::flagsT prevFlags,
  input  ctrlPkg::flagsT aluFlags,
  input  logic [1:0]     flagWrite,
  output logic           condEx,
  output ctrlPkg::flagsT nextFlags
);

  logic geOk;

  assign geOk = (prevFlags.n == prevFlags.v);  // Signed greater or equal

  always_comb begin
    case (cond)
      ctrlPkg::condEq: condEx = prevFlags.z;
      ctrlPkg::condNe: condEx = ~prevFlags.z;
      ctrlPkg::condCs: condEx = prevFlags.c;
      ctrlPkg::condCc: condEx = ~prevFlags.c;
      ctrlPkg::condMi: condEx = prevFlags.n;
      ctrlPkg::condPl: condEx = ~prevFlags.n;
      ctrlPkg::condVs: condEx = prevFlags.v;
      ctrlPkg::condVc: condEx = ~prevFlags.v;
      ctrlPkg::condHi: condEx = prevFlags.c & ~prevFlags.z;
      ctrlPkg::condLs: condEx = ~prevFlags.c | prevFlags.z;
      ctrlPkg::condGe: condEx = geOk;
      ctrlPkg::condLt: condEx = ~geOk;
      ctrlPkg::condGt: condEx = ~prevFlags.z & geOk;
      ctrlPkg::condLe: condEx = prevFlags.z | ~geOk;
      ctrlPkg::condAl: condEx = 1'b1;
      default:         condEx = 1'b0;  // Unconditional space not handled
    endcase
  end

  // Flag merge, skipped when the instruction fails its condition
  always_comb begin
    nextFlags = prevFlags;
    if (condEx && flagWrite[1]) begin
      nextFlags.n = aluFlags.n;
      nextFlags.z = aluFlags.z;
    end
    if (condEx && flagWrite[0]) begin
      nextFlags.c = aluFlags.c;
      nextFlags.v = aluFlags.v;
    end
  end

endmodule

`default_nettype wire

//--- verilog/controller.sv
`default_nettype none

module controller (
  input  logic            clk,
  input  logic            reset,
  input  ctrlPkg::instrT  instrD,
  input  ctrlPkg::flagsT  flagsE,
  input  logic            doNotWriteReg,
  input  ctrlPkg::hazardT hazard,
  // Decode
  output logic [1:0]      regSrcD,
  output logic [1:0]      immSrcD,
  output logic            multSelectD,
  // Execute
  output logic            aluSrcE,
  output logic [3:0]      aluControlE,
  output logic [2:0]      multControlE,
  output logic            branchTakenE,
  output logic [1:0]      prevCV,
  output logic            rSelectE,
  output logic [1:0]      resultSelectE,
  output logic [2:0]      shiftOpE,
  // Memory and Writeback
  output logic            memWriteM,
  output logic            memtoRegW,
  output logic            regWriteW,
  output logic            pcSrcW,
  // To hazard unit
  output logic            memtoRegE,
  output logic            regWriteM,
  output logic            pcWrPendingF
);

  ctrlPkg::exCtrlT  decCtrl;
  ctrlPkg::exCtrlT  exCtrl;
  ctrlPkg::memCtrlT memCtrlE;
  ctrlPkg::memCtrlT memCtrlM;
  ctrlPkg::memCtrlT memCtrlW;
  ctrlPkg::flagsT   prevFlags;
  ctrlPkg::flagsT   nextFlags;
  logic             condExE;
  logic             pcSrcD;

  instrDecoder dec (
    .instrD      (instrD),
    .regSrcD     (regSrcD),
    .immSrcD     (immSrcD),
    .multSelectD (multSelectD),
    .decCtrl     (decCtrl),
    .pcSrcD      (pcSrcD)
  );

  pipeReg #(.payloadT(ctrlPkg::exCtrlT)) regE (
    .clk   (clk),
    .reset (reset),
    .en    (~hazard.stallE),
    .clr   (hazard.flushE),
    .d     (decCtrl),
    .q     (exCtrl)
  );

  condCheck cond (
    .cond      (exCtrl.cond),
    .prevFlags (prevFlags),
    .aluFlags  (flagsE),
    .flagWrite (exCtrl.flagWrite),
    .condEx    (condExE),
    .nextFlags (nextFlags)
  );

  // Saved NZCV, follows each instruction that leaves E
  always_ff @(posedge clk) begin
    if (reset) begin
      prevFlags <= '0;
    end else if (!hazard.stallE) begin
      prevFlags <= nextFlags;
    end
  end

  // Write and branch controls only act when the condition passes
  assign branchTakenE = exCtrl.branch & condExE;

  always_comb begin
    memCtrlE.memWrite = exCtrl.memWrite & condExE;
    memCtrlE.memtoReg = exCtrl.memtoReg;
    memCtrlE.regWrite = exCtrl.regWrite & condExE & ~doNotWriteReg;  // CMP/TST/... keep Rd
    memCtrlE.pcSrc    = exCtrl.pcSrc & condExE;
  end

  pipeReg #(.payloadT(ctrlPkg::memCtrlT)) regM (
    .clk   (clk),
    .reset (reset),
    .en    (~hazard.stallM),
    .clr   (hazard.flushM),
    .d     (memCtrlE),
    .q     (memCtrlM)
  );

  // Writeback never stalls, a memory wait turns it into a bubble
  always_ff @(posedge clk) begin
    if (reset || hazard.flushW) begin
      memCtrlW <= '0;
    end else begin
      memCtrlW <= memCtrlM;
    end
  end

  assign aluSrcE       = exCtrl.aluSrc;
  assign aluControlE   = exCtrl.aluControl;
  assign multControlE  = exCtrl.multControl;
  assign rSelectE      = exCtrl.rSelect;
  assign resultSelectE = exCtrl.resultSelect;
  assign shiftOpE      = exCtrl.shiftOp;
  assign memtoRegE     = exCtrl.memtoReg;
  assign prevCV        = {prevFlags.c, prevFlags.v};  // Carry-in for ADC/SBC/RSC

  assign memWriteM = memCtrlM.memWrite;
  assign regWriteM = memCtrlM.regWrite;
  assign memtoRegW = memCtrlW.memtoReg;
  assign regWriteW = memCtrlW.regWrite;
  assign pcSrcW    = memCtrlW.pcSrc;

  // Ungated in E, a failing write to r15 still holds fetch for a cycle
  assign pcWrPendingF = pcSrcD | exCtrl.pcSrc | memCtrlM.pcSrc;

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`default_nettype none

module hazardUnit (
  input  ctrlPkg::regMatchT regMatch,
  input  logic              regWriteM,
  input  logic              regWriteW,
  input  logic              memtoRegE,
  input  logic              pcWrPendingF,
  input  logic              pcSrcW,
  input  logic              branchTakenE,
  input  logic              multBusyE,
  input  logic              memBusyM,
  output ctrlPkg::fwdSelT   forwardAE,
  output ctrlPkg::fwdSelT   forwardBE,
  output ctrlPkg::hazardT   hazard
);

  logic ldrStall;

  // Newest result wins
  function automatic ctrlPkg::fwdSelT fwdPick(input logic matchM, input logic matchW,
                                              input logic wrM, input logic wrW);
    ctrlPkg::fwdSelT sel;
    if (matchM && wrM) begin
      sel = ctrlPkg::fwdM;
    end else if (matchW && wrW) begin
      sel = ctrlPkg::fwdW;
    end else begin
      sel = ctrlPkg::fwdNone;
    end
    return sel;
  endfunction

  assign forwardAE = fwdPick(regMatch.match1EM, regMatch.match1EW, regWriteM, regWriteW);
  assign forwardBE = fwdPick(regMatch.match2EM, regMatch.match2EW, regWriteM, regWriteW);

  assign ldrStall = regMatch.match12DE & memtoRegE;  // Load result not ready yet

  always_comb begin
    hazard.flushD = pcWrPendingF | pcSrcW | branchTakenE;
    if (memBusyM) begin
      // Whole front end frozen, W gets a bubble
      hazard.stallF = 1'b1;
      hazard.stallD = 1'b1;
      hazard.stallE = 1'b1;
      hazard.flushE = 1'b0;
      hazard.stallM = 1'b1;
      hazard.flushM = 1'b0;
      hazard.flushW = 1'b1;
    end else if (multBusyE) begin
      hazard.stallF = 1'b1;
      hazard.stallD = 1'b1;
      hazard.stallE = 1'b1;
      hazard.flushE = 1'b0;
      hazard.stallM = 1'b0;
      hazard.flushM = 1'b1;  // Bubble behind the held multiply
      hazard.flushW = 1'b0;
    end else begin
      hazard.stallF = ldrStall | pcWrPendingF;
      hazard.stallD = ldrStall;
      hazard.stallE = 1'b0;
      hazard.flushE = ldrStall | branchTakenE;
      hazard.stallM = 1'b0;
      hazard.flushM = 1'b0;
      hazard.flushW = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/controlPath.sv
`default_nettype none

module controlPath (
  input  logic              clk,
  input  logic              reset,
  input  ctrlPkg::instrT    instrD,
  input  ctrlPkg::flagsT    flagsE,
  input  logic              doNotWriteReg,
  input  ctrlPkg::regMatchT regMatch,
  input  logic              multBusyE,
  input  logic              memBusyM,
  output logic [1:0]        regSrcD,
  output logic [1:0]        immSrcD,
  output logic              multSelectD,
  output logic              aluSrcE,
  output logic [3:0]        aluControlE,
  output logic [2:0]        multControlE,
  output logic              branchTakenE,
  output logic [1:0]        prevCV,
  output logic              rSelectE,
  output logic [1:0]        resultSelectE,
  output logic [2:0]        shiftOpE,
  output logic              memWriteM,
  output logic              memtoRegW,
  output logic              regWriteW,
  output logic              pcSrcW,
  output ctrlPkg::fwdSelT   forwardAE,
  output ctrlPkg::fwdSelT   forwardBE,
  output logic              stallF,
  output logic              stallD,
  output logic              flushD
);

  ctrlPkg::hazardT hazard;
  logic            memtoRegE;
  logic            regWriteM;
  logic            pcWrPendingF;

  controller ctrl (
    .clk           (clk),
    .reset         (reset),
    .instrD        (instrD),
    .flagsE        (flagsE),
    .doNotWriteReg (doNotWriteReg),
    .hazard        (hazard),
    .regSrcD       (regSrcD),
    .immSrcD       (immSrcD),
    .multSelectD   (multSelectD),
    .aluSrcE       (aluSrcE),
    .aluControlE   (aluControlE),
    .multControlE  (multControlE),
    .branchTakenE  (branchTakenE),
    .prevCV        (prevCV),
    .rSelectE      (rSelectE),
    .resultSelectE (resultSelectE),
    .shiftOpE      (shiftOpE),
    .memWriteM     (memWriteM),
    .memtoRegW     (memtoRegW),
    .regWriteW     (regWriteW),
    .pcSrcW        (pcSrcW),
    .memtoRegE     (memtoRegE),
    .regWriteM     (regWriteM),
    .pcWrPendingF  (pcWrPendingF)
  );

  hazardUnit hzd (
    .regMatch     (regMatch),
    .regWriteM    (regWriteM),
    .regWriteW    (regWriteW),
    .memtoRegE    (memtoRegE),
    .pcWrPendingF (pcWrPendingF),
    .pcSrcW       (pcSrcW),
    .branchTakenE (branchTakenE),
    .multBusyE    (multBusyE),
    .memBusyM     (memBusyM),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE),
    .hazard       (hazard)
  );

  // Datapath side of the hazard bundle
  assign stallF = hazard.stallF;
  assign stallD = hazard.stallD;
  assign flushD = hazard.flushD;

endmodule

`default_nettype wire

//--- sim/controlPathTb.sv
`default_nettype none

module controlPathTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int maxCycles = 400;  // Tests need about 150 cycles
  localparam ctrlPkg::instrT nopInstr = 32'hE1A0_0000;  // MOV r0, r0
  localparam ctrlPkg::instrT ldrInstr = 32'hE590_1004;  // LDR r1, [r0, #4]
  localparam ctrlPkg::instrT strInstr = 32'hE580_1000;  // STR r1, [r0]
  localparam ctrlPkg::instrT mulInstr = 32'hE002_0291;  // MUL r2, r1, r2

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       multSelect;
    logic       aluSrc;
    logic [3:0] aluControl;
    logic [2:0] multControl;
    logic [1:0] resultSelect;
    logic       rSelect;
    logic [2:0] shiftOp;
  } decodeT;

  logic              clk;
  logic              reset;
  ctrlPkg::instrT    instrD;
  ctrlPkg::flagsT    flagsE;
  logic              doNotWriteReg;
  ctrlPkg::regMatchT regMatch;
  logic              multBusyE;
  logic              memBusyM;
  logic [1:0]        regSrcD;
  logic [1:0]        immSrcD;
  logic              multSelectD;
  logic              aluSrcE;
  logic [3:0]        aluControlE;
  logic [2:0]        multControlE;
  logic              branchTakenE;
  logic [1:0]        prevCV;
  logic              rSelectE;
  logic [1:0]        resultSelectE;
  logic [2:0]        shiftOpE;
  logic              memWriteM;
  logic              memtoRegW;
  logic              regWriteW;
  logic              pcSrcW;
  ctrlPkg::fwdSelT   forwardAE;
  ctrlPkg::fwdSelT   forwardBE;
  logic              stallF;
  logic              stallD;
  logic              flushD;
  int                errorCount;
  int                cycleCount;

  controlPath uut (
    .clk           (clk),
    .reset         (reset),
    .instrD        (instrD),
    .flagsE        (flagsE),
    .doNotWriteReg (doNotWriteReg),
    .regMatch      (regMatch),
    .multBusyE     (multBusyE),
    .memBusyM      (memBusyM),
    .regSrcD       (regSrcD),
    .immSrcD       (immSrcD),
    .multSelectD   (multSelectD),
    .aluSrcE       (aluSrcE),
    .aluControlE   (aluControlE),
    .multControlE  (multControlE),
    .branchTakenE  (branchTakenE),
    .prevCV        (prevCV),
    .rSelectE      (rSelectE),
    .resultSelectE (resultSelectE),
    .shiftOpE      (shiftOpE),
    .memWriteM     (memWriteM),
    .memtoRegW     (memtoRegW),
    .regWriteW     (regWriteW),
    .pcSrcW        (pcSrcW),
    .forwardAE     (forwardAE),
    .forwardBE     (forwardBE),
    .stallF        (stallF),
    .stallD        (stallD),
    .flushD        (flushD)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= maxCycles) begin
      $display("timeout: run did not finish within %0d cycles", maxCycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Decode table as the ARM encoding defines it
  function automatic decodeT refDecode(input ctrlPkg::instrT instr);
    decodeT r;
    logic   isMul;
    logic   isDpReg;
    r = '0;
    isDpReg = (instr[27:25] == 3'b000);
    isMul = isDpReg && (instr[7:4] == 4'b1001);
    r.aluControl = 4'b0100;  // ADD for addresses and targets
    r.multControl = instr[23:21];
    r.shiftOp = instr[6:4];  // Shift type and register-shift bit
    case (instr[27:26])
      2'b00: begin
        r.aluControl = instr[24:21];
        r.aluSrc = instr[25];
        r.multSelect = isMul;
        r.resultSelect = {isMul, isDpReg & instr[4]};
        r.rSelect = isDpReg & !instr[4];
      end
      2'b01: begin
        r.immSrc = 2'b01;
        r.aluSrc = 1'b1;
        r.regSrc = instr[20] ? 2'b00 : 2'b10;
      end
      2'b10: begin
        r.regSrc = 2'b01;
        r.immSrc = 2'b10;
        r.aluSrc = 1'b1;
      end
      default: ;
    endcase
    return r;
  endfunction

  // Flags as {n, z, c, v}
  function automatic logic condPasses(input logic [3:0] cond, input logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cond)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return c;
      4'h3: return !c;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return c && !z;
      4'h9: return !c || z;
      4'ha: return n == v;
      4'hb: return n != v;
      4'hc: return !z && (n == v);
      4'hd: return z || (n != v);
      4'he: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic ctrlPkg::fwdSelT expectedFwd(input logic matchM, input logic matchW,
                                                  input logic wrM, input logic wrW);
    if (matchM && wrM) begin
      return ctrlPkg::fwdM;
    end
    if (matchW && wrW) begin
      return ctrlPkg::fwdW;
    end
    return ctrlPkg::fwdNone;
  endfunction

  // Kinds 0..6: DP imm, DP reg, DP reg-shifted reg, MUL, LDR, STR, B
  function automatic ctrlPkg::instrT randomInstr(input int kind);
    logic [3:0]  cond;
    logic [3:0]  op;
    logic        s;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [3:0]  rs;
    logic [3:0]  rm;
    logic [11:0] imm;
    cond = 4'($urandom % 15);
    op = 4'($urandom);
    s = 1'($urandom);
    rn = 4'($urandom);
    rd = 4'($urandom);
    rs = 4'($urandom);
    rm = 4'($urandom);
    imm = 12'($urandom);
    case (kind)
      0: return {cond, 3'b001, op, s, rn, rd, imm};
      1: return {cond, 3'b000, op, s, rn, rd, imm[11:7], imm[6:5], 1'b0, rm};
      2: return {cond, 3'b000, op, s, rn, rd, rs, 1'b0, imm[6:5], 1'b1, rm};
      3: return {cond, 6'b000000, op[0], s, rd, rn, rs, 4'b1001, rm};
      4: return {cond, 8'b0101_1001, rn, rd, imm};
      5: return {cond, 8'b0101_1000, rn, rd, imm};
      default: return {cond, 4'b1010, imm, imm};
    endcase
  endfunction

  task automatic checkValue(input string testName, input string sigName,
                            input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error %s %s: expected %0h, actual %0h", testName, sigName, expected, actual);
      errorCount++;
    end
  endtask

  task automatic issue(input ctrlPkg::instrT instr);
    @(posedge clk);
    #2;
    instrD = instr;
  endtask

  task automatic sample();
    #5;
  endtask

  task automatic drain();
    repeat (4) issue(nopInstr);
  endtask

  task automatic decodeTableTest();
    ctrlPkg::instrT instr;
    decodeT         exp;
    int             round;
    int             kind;
    for (round = 0; round < 2; round++) begin
      for (kind = 0; kind < 7; kind++) begin
        instr = randomInstr(kind);
        exp = refDecode(instr);
        issue(instr);
        sample();
        checkValue("decode", "D controls", {exp.regSrc, exp.immSrc, exp.multSelect},
                   {regSrcD, immSrcD, multSelectD});
        issue(nopInstr);  // Absorbs a flush behind a taken branch
        sample();
        checkValue("decode", "E controls",
                   {exp.aluSrc, exp.aluControl, exp.multControl, exp.resultSelect},
                   {aluSrcE, aluControlE, multControlE, resultSelectE});
        checkValue("decode", "E shift controls", {exp.rSelect, exp.shiftOp},
                   {rSelectE, shiftOpE});
      end
    end
  endtask

  task automatic condGatingTest();
    logic [3:0] f;
    logic [3:0] condB;
    logic [3:0] condS;
    int         i;
    for (i = 0; i < 4; i++) begin
      f = 4'($urandom);
      condB = 4'($urandom % 15);
      condS = 4'($urandom % 15);
      issue(32'hE091_3002);  // ADDS r3, r1, r2
      issue(nopInstr);
      flagsE = f;
      issue({condB, 4'b1010, 24'h000010});
      issue(nopInstr);
      sample();
      checkValue("condGate", "branchTakenE", condPasses(condB, f), branchTakenE);
      issue({condS, 8'b0101_1000, 4'($urandom), 4'($urandom), 12'($urandom)});
      issue(nopInstr);
      issue(nopInstr);
      sample();
      checkValue("condGate", "memWriteM", condPasses(condS, f), memWriteM);
    end
  endtask

  task automatic flagWriteTest();
    logic [3:0] model;
    issue(32'hE091_3002);  // ADDS r3, r1, r2
    issue(32'hE011_3002);  // ANDS r3, r1, r2
    flagsE = 4'b0011;
    model = 4'b0011;
    issue(nopInstr);
    flagsE = 4'b1100;  // Logic op, C and V must stay
    model = {flagsE.n, flagsE.z, model[1:0]};
    sample();
    checkValue("flagWrite", "prevCV after ADDS", 2'b11, prevCV);
    issue(32'h0A00_0004);  // BEQ
    sample();
    checkValue("flagWrite", "prevCV after ANDS", model[1:0], prevCV);
    issue(nopInstr);
    sample();
    checkValue("flagWrite", "BEQ taken", condPasses(4'h0, model), branchTakenE);
    issue(32'h3A00_0004);  // BCC
    issue(nopInstr);
    sample();
    checkValue("flagWrite", "BCC taken", condPasses(4'h3, model), branchTakenE);
  endtask

  task automatic loadUseTest();
    drain();
    issue(ldrInstr);
    issue(32'hE081_2001);  // ADD r2, r1, r1 reads the load
    regMatch.match12DE = 1'b1;
    sample();
    checkValue("loadUse", "stallF", 1'b1, stallF);
    checkValue("loadUse", "stallD", 1'b1, stallD);
    issue(32'hE081_2001);  // Held in D
    regMatch = '0;
    sample();
    checkValue("loadUse", "stallD released", 1'b0, stallD);
    issue(nopInstr);
    regMatch.match1EM = 1'b1;  // Bubble in M must not forward
    sample();
    checkValue("loadUse", "forwardAE", ctrlPkg::fwdNone, forwardAE);
    checkValue("loadUse", "memtoRegW", 1'b1, memtoRegW);
    issue(nopInstr);
    regMatch = '0;
    sample();
    checkValue("loadUse", "regWriteW bubble", 1'b0, regWriteW);
  endtask

  task automatic branchPcTest();
    int i;
    drain();
    issue(32'hEA00_0002);  // B always
    sample();
    checkValue("branchPc", "stallF pending B", 1'b1, stallF);
    issue(nopInstr);
    sample();
    checkValue("branchPc", "branchTakenE", 1'b1, branchTakenE);
    checkValue("branchPc", "flushD", 1'b1, flushD);
    drain();
    issue(32'hE1A0_F000);  // MOV pc, r0
    for (i = 0; i < 4; i++) begin
      if (i > 0) begin
        issue(nopInstr);
      end
      sample();
      checkValue("branchPc", "stallF", i < 3, stallF);
      checkValue("branchPc", "pcSrcW", i == 3, pcSrcW);
    end
    checkValue("branchPc", "flushD on pcSrcW", 1'b1, flushD);
  endtask

  task automatic fwdWaitTest();
    int combo;
    drain();  // M and W now both write r0
    for (combo = 0; combo < 16; combo++) begin
      issue(nopInstr);
      regMatch = {4'(combo), 1'b0};
      sample();
      checkValue("fwdWait", "forwardAE",
                 expectedFwd(regMatch.match1EM, regMatch.match1EW, 1'b1, 1'b1), forwardAE);
      checkValue("fwdWait", "forwardBE",
                 expectedFwd(regMatch.match2EM, regMatch.match2EW, 1'b1, 1'b1), forwardBE);
    end
    issue(nopInstr);
    doNotWriteReg = 1'b1;
    issue(nopInstr);
    doNotWriteReg = 1'b0;
    regMatch = 5'b10110;  // A matches M and W, B matches W only
    sample();
    checkValue("fwdWait", "forwardAE M idle", expectedFwd(1'b1, 1'b1, 1'b0, 1'b1), forwardAE);
    issue(nopInstr);
    sample();
    checkValue("fwdWait", "forwardBE W idle", expectedFwd(1'b0, 1'b1, 1'b1, 1'b0), forwardBE);
    regMatch = '0;
    // Multiply wait
    drain();
    issue(mulInstr);
    issue(nopInstr);
    multBusyE = 1'b1;
    sample();
    checkValue("fwdWait", "resultSelectE MUL", 2'b11, resultSelectE);
    checkValue("fwdWait", "stallD mult", 1'b1, stallD);
    issue(nopInstr);
    regMatch.match1EM = 1'b1;
    sample();
    checkValue("fwdWait", "resultSelectE held", 2'b11, resultSelectE);
    checkValue("fwdWait", "M bubble", ctrlPkg::fwdNone, forwardAE);
    issue(nopInstr);
    multBusyE = 1'b0;
    sample();
    checkValue("fwdWait", "resultSelectE last", 2'b11, resultSelectE);
    issue(nopInstr);
    sample();
    checkValue("fwdWait", "resultSelectE next", 2'b00, resultSelectE);
    checkValue("fwdWait", "MUL in M", ctrlPkg::fwdM, forwardAE);
    regMatch = '0;
    // Memory wait with a store held in M
    drain();
    issue(strInstr);
    issue(nopInstr);
    issue(nopInstr);
    memBusyM = 1'b1;
    sample();
    checkValue("fwdWait", "memWriteM", 1'b1, memWriteM);
    checkValue("fwdWait", "stallF mem", 1'b1, stallF);
    issue(nopInstr);
    sample();
    checkValue("fwdWait", "memWriteM held", 1'b1, memWriteM);
    issue(nopInstr);
    memBusyM = 1'b0;
    sample();
    checkValue("fwdWait", "memWriteM last", 1'b1, memWriteM);
    issue(nopInstr);
    sample();
    checkValue("fwdWait", "memWriteM done", 1'b0, memWriteM);
    // Same wait with a load, W must see bubbles
    drain();
    issue(ldrInstr);
    issue(nopInstr);
    issue(nopInstr);
    memBusyM = 1'b1;
    issue(nopInstr);
    sample();
    checkValue("fwdWait", "regWriteW bubble", 1'b0, regWriteW);
    checkValue("fwdWait", "memtoRegW bubble", 1'b0, memtoRegW);
    issue(nopInstr);
    memBusyM = 1'b0;
    sample();
    checkValue("fwdWait", "regWriteW still bubble", 1'b0, regWriteW);
    issue(nopInstr);
    sample();
    checkValue("fwdWait", "LDR in W", 2'b11, {regWriteW, memtoRegW});
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    instrD = nopInstr;
    flagsE = '0;
    doNotWriteReg = 1'b0;
    regMatch = '0;
    multBusyE = 1'b0;
    memBusyM = 1'b0;
    errorCount = 0;
    cycleCount = 0;
    void'($urandom(32'h7a16_9f9e));
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    decodeTableTest();
    condGatingTest();
    flagWriteTest();
    loadUseTest();
    branchPcTest();
    fwdWaitTest();
    @(posedge clk);
    $display("errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
verilog/ctrlPkg.sv
verilog/pipeReg.sv
verilog/instrDecoder.sv
verilog/condCheck.sv
verilog/controller.sv
verilog/hazardUnit.sv
verilog/controlPath.sv
sim/controlPathTb.sv

//--- Bender.yml
package:
  name: control_path

sources:
  - verilog/ctrlPkg.sv
  - verilog/pipeReg.sv
  - verilog/instrDecoder.sv
  - verilog/condCheck.sv
  - verilog/controller.sv
  - verilog/hazardUnit.sv
  - verilog/controlPath.sv
  - target: test
    files:
      - sim/controlPathTb.sv
